//--- Makefile
BIN  = obj_dir/Vrename_tb
SRCS = $(shell grep -v '^+' verilog.f) include/rename_defs.svh

.PHONY: all run clean

all: run

$(BIN): verilog.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps --top-module rename_tb -f verilog.f

run: $(BIN)
	$(BIN) > sim.log 2>&1; cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/rename_tb.sv
`include "rename_defs.svh"

module rename_tb import rename_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF        = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 64;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MARGIN_CYCLES   = 200;
    localparam int ACT_IDLE        = 0;
    localparam int ACT_DISPATCH    = 1;
    localparam int ACT_WB          = 2;
    localparam int ACT_COMMIT      = 3;

    logic      clk_i;
    logic      reset_i;
    logic      dispatch_en_i;
    arf_idx_t  dispatch_dst_i;
    arf_idx_t  rs1_idx_i;
    arf_idx_t  rs2_idx_i;
    reg_data_t rs1_data_o;
    reg_data_t rs2_data_o;
    logic      rs1_ready_o;
    logic      rs2_ready_o;
    rrf_tag_t  alloc_tag_o;
    logic      full_o;
    logic      commit_en_i;
    logic      commit_ready_o;

    // ports 0..4 are alu1, alu2, ldst, mul, branch
    logic      wb_we   [5];
    rrf_tag_t  wb_tag  [5];
    reg_data_t wb_data [5];

    // reference model state
    reg_data_t m_arf  [`ARF_NUM];
    logic      m_busy [`ARF_NUM];
    rrf_tag_t  m_map  [`ARF_NUM];
    reg_data_t m_rrf  [`RRF_NUM];
    logic      m_done [`RRF_NUM];
    arf_idx_t  m_dst  [`RRF_NUM];
    rrf_tag_t  m_head;
    rrf_tag_t  m_tail;
    int        m_count;
    rrf_tag_t  pending [$];

    logic        exp_full;
    logic        exp_commit_ready;
    rrf_tag_t    exp_alloc_tag;
    logic        exp_rs1_ready;
    logic        exp_rs2_ready;
    reg_data_t   exp_rs1_data;
    reg_data_t   exp_rs2_data;
    string       test_name;
    int          errors;
    logic [31:0] lfsr;

    rename_top rename_top_i (
        .clk_i, .reset_i, .dispatch_en_i, .dispatch_dst_i, .rs1_idx_i, .rs2_idx_i,
        .rs1_data_o, .rs1_ready_o, .rs2_data_o, .rs2_ready_o, .alloc_tag_o, .full_o,
        .wb_alu1_we_i(wb_we[0]), .wb_alu1_tag_i(wb_tag[0]), .wb_alu1_data_i(wb_data[0]),
        .wb_alu2_we_i(wb_we[1]), .wb_alu2_tag_i(wb_tag[1]), .wb_alu2_data_i(wb_data[1]),
        .wb_ldst_we_i(wb_we[2]), .wb_ldst_tag_i(wb_tag[2]), .wb_ldst_data_i(wb_data[2]),
        .wb_mul_we_i(wb_we[3]), .wb_mul_tag_i(wb_tag[3]), .wb_mul_data_i(wb_data[3]),
        .wb_branch_we_i(wb_we[4]), .wb_branch_tag_i(wb_tag[4]),
        .wb_branch_data_i(wb_data[4]),
        .commit_en_i, .commit_ready_o
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #CLK_HALF clk_i = ~clk_i;
        end
    end

    // fibonacci taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
    endtask

    // operand seen before this cycle's edge, with same-cycle writeback forwarding
    task automatic model_operand(input arf_idx_t idx, output reg_data_t d, output logic rdy);
        rrf_tag_t t;
        t = m_map[idx];
        d = m_arf[idx];
        rdy = 1'b1;
        if (m_busy[idx]) begin
            d = m_rrf[t];
            rdy = m_done[t];
            for (int p = 4; p >= 0; p--) begin
                if (!m_done[t] && wb_we[p] && wb_tag[p] == t) begin
                    d = wb_data[p];
                    rdy = 1'b1;
                end
            end
        end
    endtask

    // mode 0 fills, mode 1 drains, mode 2 mixes
    task automatic pick_action(input int mode, output int act);
        logic [31:0] r;
        take_bits(2, r);
        case (mode)
            0: act = (r == 3) ? ACT_WB : ACT_DISPATCH;
            1: act = (r == 0) ? ACT_WB : ACT_COMMIT;
            default: act = (r == 0) ? ACT_DISPATCH : (r == 2) ? ACT_COMMIT : ACT_WB;
        endcase
    endtask

    task automatic run_cycle(input int action, input int rs1_hint);
        logic [31:0] r;
        int          act;
        int          a;
        int          b;
        int          p0;
        int          p1;
        rrf_tag_t    t;
        act = action;
        @(negedge clk_i);
        for (int p = 0; p < 5; p++) begin
            wb_we[p] = 1'b0;
        end
        take_bits(`ARF_SEL, r);
        dispatch_dst_i = arf_idx_t'(r);
        take_bits(`ARF_SEL, r);
        rs1_idx_i = arf_idx_t'(r);
        take_bits(`ARF_SEL, r);
        rs2_idx_i = arf_idx_t'(r);
        // fall back to a legal action
        if (act == ACT_DISPATCH && m_count == `RRF_NUM) begin
            act = ACT_WB;
        end
        if (act == ACT_COMMIT && !(m_count > 0 && m_done[m_tail])) begin
            act = ACT_WB;
        end
        if (act == ACT_WB && pending.size() == 0) begin
            act = ACT_IDLE;
        end
        if (act == ACT_WB) begin
            take_bits(3, r);
            p0 = int'(r) % 5;
            take_bits(2, r);
            p1 = (p0 + 1 + int'(r)) % 5;
            take_bits(4, r);
            a = int'(r) % pending.size();
            take_bits(32, r);
            wb_we[p0]   = 1'b1;
            wb_tag[p0]  = pending[a];
            wb_data[p0] = reg_data_t'(r);
            // read the destination of the result in flight to hit the bypass
            rs1_idx_i = m_dst[pending[a]];
            take_bits(1, r);
            if (r[0] && pending.size() > 1) begin
                take_bits(4, r);
                b = (a + 1 + int'(r) % (pending.size() - 1)) % pending.size();
                take_bits(32, r);
                wb_we[p1]   = 1'b1;
                wb_tag[p1]  = pending[b];
                wb_data[p1] = reg_data_t'(r);
            end
        end
        if (rs1_hint >= 0) begin
            rs1_idx_i = arf_idx_t'(rs1_hint);
        end
        dispatch_en_i = (act == ACT_DISPATCH);
        commit_en_i   = (act == ACT_COMMIT);

        exp_full         = (m_count == `RRF_NUM);
        exp_alloc_tag    = m_head;
        exp_commit_ready = (m_count > 0) && m_done[m_tail];
        model_operand(rs1_idx_i, exp_rs1_data, exp_rs1_ready);
        model_operand(rs2_idx_i, exp_rs2_data, exp_rs2_ready);

        // model state after the coming edge
        case (act)
            ACT_DISPATCH: begin
                m_dst[m_head]          = dispatch_dst_i;
                m_done[m_head]         = 1'b0;
                m_busy[dispatch_dst_i] = 1'b1;
                m_map[dispatch_dst_i]  = m_head;
                pending.push_back(m_head);
                m_head = m_head + 1'b1;
                m_count++;
            end
            ACT_WB: begin
                for (int p = 0; p < 5; p++) begin
                    if (wb_we[p]) begin
                        m_rrf[wb_tag[p]]  = wb_data[p];
                        m_done[wb_tag[p]] = 1'b1;
                        for (int k = pending.size() - 1; k >= 0; k--) begin
                            if (pending[k] == wb_tag[p]) begin
                                pending.delete(k);
                            end
                        end
                    end
                end
            end
            ACT_COMMIT: begin
                t = m_tail;
                m_arf[m_dst[t]] = m_rrf[t];
                if (m_map[m_dst[t]] == t) begin
                    m_busy[m_dst[t]] = 1'b0;
                end
                m_tail = m_tail + 1'b1;
                m_count--;
            end
            default: begin
            end
        endcase
    endtask

    a_full: assert property (@(posedge clk_i) disable iff (reset_i) full_o == exp_full)
        else report_mismatch("full_o", 32'(exp_full), 32'($sampled(full_o)));
    a_alloc_tag: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_tag_o == exp_alloc_tag)
        else report_mismatch("alloc_tag_o", 32'(exp_alloc_tag), 32'($sampled(alloc_tag_o)));
    a_commit_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_ready_o == exp_commit_ready)
        else report_mismatch("commit_ready_o", 32'(exp_commit_ready),
                             32'($sampled(commit_ready_o)));
    a_rs1_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        rs1_ready_o == exp_rs1_ready)
        else report_mismatch("rs1_ready_o", 32'(exp_rs1_ready), 32'($sampled(rs1_ready_o)));
    a_rs2_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        rs2_ready_o == exp_rs2_ready)
        else report_mismatch("rs2_ready_o", 32'(exp_rs2_ready), 32'($sampled(rs2_ready_o)));
    // data only matters once the operand is ready
    a_rs1_data: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_rs1_ready |-> rs1_data_o == exp_rs1_data)
        else report_mismatch("rs1_data_o", exp_rs1_data, $sampled(rs1_data_o));
    a_rs2_data: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_rs2_ready |-> rs2_data_o == exp_rs2_data)
        else report_mismatch("rs2_data_o", exp_rs2_data, $sampled(rs2_data_o));

    initial begin
        int last_dst;
        int act;
        errors = 0;
        lfsr = 32'h4aa66178;
        reset_i = 1'b1;
        dispatch_en_i = 1'b0;
        dispatch_dst_i = '0;
        commit_en_i = 1'b0;
        rs1_idx_i = '0;
        rs2_idx_i = '0;
        for (int p = 0; p < 5; p++) begin
            wb_we[p] = 1'b0;
            wb_tag[p] = '0;
            wb_data[p] = '0;
        end
        for (int i = 0; i < `ARF_NUM; i++) begin
            m_arf[i] = '0;
            m_busy[i] = 1'b0;
            m_map[i] = '0;
        end
        for (int i = 0; i < `RRF_NUM; i++) begin
            m_rrf[i] = '0;
            m_done[i] = 1'b0;
            m_dst[i] = '0;
        end
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        exp_full = 1'b0;
        exp_commit_ready = 1'b0;
        exp_alloc_tag = '0;
        exp_rs1_ready = 1'b1;
        exp_rs2_ready = 1'b1;
        exp_rs1_data = '0;
        exp_rs2_data = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            run_cycle(ACT_IDLE, -1);
        end

        // read back the previous destination while its producer is pending
        test_name = "allocation";
        last_dst = -1;
        for (int i = 0; i < `RRF_NUM; i++) begin
            run_cycle(ACT_DISPATCH, last_dst);
            last_dst = int'(dispatch_dst_i);
        end
        run_cycle(ACT_IDLE, -1);

        test_name = "writeback";
        while (pending.size() > 0) begin
            run_cycle(ACT_WB, -1);
        end

        test_name = "commit";
        while (m_count > 0) begin
            run_cycle(ACT_COMMIT, int'(m_dst[m_tail - 1'b1]));
        end

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pick_action((i / 100) % 3, act);
            run_cycle(act, -1);
        end

        @(negedge clk_i);
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) begin
            @(posedge clk_i);
        end
        $display("run timed out before the stimulus finished");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- design/arf_table.sv
`include "rename_defs.svh"

module arf_table import rename_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  arf_idx_t  rs1_idx_i,
    input  arf_idx_t  rs2_idx_i,
    rrf_read_if.requester rd,
    output reg_data_t rs1_data_o,
    output reg_data_t rs2_data_o,
    output logic      rs1_ready_o,
    output logic      rs2_ready_o,
    input  logic      rename_en_i,
    input  arf_idx_t  rename_dst_i,
    input  rrf_tag_t  rename_tag_i,
    input  logic      commit_en_i,
    input  arf_idx_t  commit_dst_i,
    input  rrf_tag_t  commit_tag_i,
    input  reg_data_t commit_data_i
);

    reg_data_t           arf_data [`ARF_NUM];
    logic [`ARF_NUM-1:0] busy;
    rrf_tag_t            tag_mem  [`ARF_NUM];

    logic rs1_busy;
    logic rs2_busy;

    assign rs1_busy = busy[rs1_idx_i];
    assign rs2_busy = busy[rs2_idx_i];

    // renamed sources are looked up in the RRF
    assign rd.rs1_tag = tag_mem[rs1_idx_i];
    assign rd.rs2_tag = tag_mem[rs2_idx_i];

    assign rs1_data_o  = rs1_busy ? rd.rs1_data : arf_data[rs1_idx_i];
    assign rs2_data_o  = rs2_busy ? rd.rs2_data : arf_data[rs2_idx_i];
    assign rs1_ready_o = rs1_busy ? rd.rs1_valid : 1'b1;
    assign rs2_ready_o = rs2_busy ? rd.rs2_valid : 1'b1;

    // architectural state and busy bits
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy <= '0;
            for (int i = 0; i < `ARF_NUM; i++) begin
                arf_data[i] <= '0;
            end
        end else begin
            if (commit_en_i) begin
                arf_data[commit_dst_i] <= commit_data_i;
                // a younger rename keeps the register busy
                if (tag_mem[commit_dst_i] == commit_tag_i) begin
                    busy[commit_dst_i] <= 1'b0;
                end
            end
            // last assignment wins, so a new mapping overrides the commit clear
            if (rename_en_i) begin
                busy[rename_dst_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rename_en_i) begin
            tag_mem[rename_dst_i] <= rename_tag_i;
        end
    end

    // a retiring entry must still own or have owned a busy mapping
    a_commit_to_busy: assert property (
        @(posedge clk_i) disable iff (reset_i) commit_en_i |-> busy[commit_dst_i]
    ) else $error("arf_table: commit to a register that is not renamed");

endmodule

//--- design/rename_ifs.sv
// results coming back from the five execution units
interface wb_bus_if import rename_pkg::*; ();
    logic      alu1_we;
    rrf_tag_t  alu1_tag;
    reg_data_t alu1_data;
    logic      alu2_we;
    rrf_tag_t  alu2_tag;
    reg_data_t alu2_data;
    logic      ldst_we;
    rrf_tag_t  ldst_tag;
    reg_data_t ldst_data;
    logic      mul_we;
    rrf_tag_t  mul_tag;
    reg_data_t mul_data;
    logic      branch_we;
    rrf_tag_t  branch_tag;
    reg_data_t branch_data;

    modport source (
        output alu1_we, alu1_tag, alu1_data, alu2_we, alu2_tag, alu2_data,
        output ldst_we, ldst_tag, ldst_data, mul_we, mul_tag, mul_data,
        output branch_we, branch_tag, branch_data
    );
    modport sink (
        input alu1_we, alu1_tag, alu1_data, alu2_we, alu2_tag, alu2_data,
        input ldst_we, ldst_tag, ldst_data, mul_we, mul_tag, mul_data,
        input branch_we, branch_tag, branch_data
    );
endinterface

// operand lookup of renamed sources
interface rrf_read_if import rename_pkg::*; ();
    rrf_tag_t  rs1_tag;
    rrf_tag_t  rs2_tag;
    reg_data_t rs1_data;
    reg_data_t rs2_data;
    logic      rs1_valid;
    logic      rs2_valid;

    modport requester (output rs1_tag, rs2_tag, input rs1_data, rs2_data, rs1_valid, rs2_valid);
    modport responder (input rs1_tag, rs2_tag, output rs1_data, rs2_data, rs1_valid, rs2_valid);
endinterface

//--- design/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    // index of one rename entry
    typedef logic [`RRF_SEL-1:0] rrf_tag_t;

    // index of one architectural register
    typedef logic [`ARF_SEL-1:0] arf_idx_t;

    // one register value
    typedef logic [`DATA_LEN-1:0] reg_data_t;

    // entries in flight, one extra bit so that full fits
    typedef logic [`RRF_SEL:0] rrf_count_t;

endpackage

//--- design/rename_rrf.sv
`include "rename_defs.svh"

module rename_rrf import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    wb_bus_if.sink   wb,
    rrf_read_if.responder rd,
    input  logic     alloc_en_i,
    input  rrf_tag_t alloc_tag_i,
    input  rrf_tag_t retire_tag_i,
    output logic      retire_valid_o,
    output reg_data_t retire_data_o
);

    localparam int WB_PORTS = 5;

    logic [`RRF_NUM-1:0] valid;
    reg_data_t           data_mem [`RRF_NUM];

    // writeback ports in bypass priority order, alu1 first
    logic      [WB_PORTS-1:0] wb_we;
    rrf_tag_t  [WB_PORTS-1:0] wb_tag;
    reg_data_t [WB_PORTS-1:0] wb_data;

    logic [WB_PORTS-1:0] rs1_match;
    logic [WB_PORTS-1:0] rs2_match;
    logic                rs1_bypass;
    logic                rs2_bypass;
    logic                wb_collide;
    logic                wb_hits_alloc;

    assign wb_we   = {wb.branch_we, wb.mul_we, wb.ldst_we, wb.alu2_we, wb.alu1_we};
    assign wb_tag  = {wb.branch_tag, wb.mul_tag, wb.ldst_tag, wb.alu2_tag, wb.alu1_tag};
    assign wb_data = {wb.branch_data, wb.mul_data, wb.ldst_data, wb.alu2_data, wb.alu1_data};

    // which enabled ports carry this tag
    function automatic logic [WB_PORTS-1:0] tag_match(
        input rrf_tag_t                tag,
        input logic     [WB_PORTS-1:0] we,
        input rrf_tag_t [WB_PORTS-1:0] tags
    );
        logic [WB_PORTS-1:0] m;
        for (int i = 0; i < WB_PORTS; i++) begin
            m[i] = we[i] && (tags[i] == tag);
        end
        return m;
    endfunction

    // lowest port index wins
    function automatic reg_data_t fwd_data(
        input logic      [WB_PORTS-1:0] match,
        input reg_data_t [WB_PORTS-1:0] datas
    );
        reg_data_t d;
        d = '0;
        for (int i = WB_PORTS - 1; i >= 0; i--) begin
            if (match[i]) begin
                d = datas[i];
            end
        end
        return d;
    endfunction

    assign rs1_match = tag_match(rd.rs1_tag, wb_we, wb_tag);
    assign rs2_match = tag_match(rd.rs2_tag, wb_we, wb_tag);

    // bypass only while the stored entry is still pending
    assign rs1_bypass = !valid[rd.rs1_tag] && (|rs1_match);
    assign rs2_bypass = !valid[rd.rs2_tag] && (|rs2_match);

    assign rd.rs1_valid = valid[rd.rs1_tag] || rs1_bypass;
    assign rd.rs2_valid = valid[rd.rs2_tag] || rs2_bypass;
    assign rd.rs1_data  = rs1_bypass ? fwd_data(rs1_match, wb_data) : data_mem[rd.rs1_tag];
    assign rd.rs2_data  = rs2_bypass ? fwd_data(rs2_match, wb_data) : data_mem[rd.rs2_tag];

    // retire port for commit
    assign retire_valid_o = valid[retire_tag_i];
    assign retire_data_o  = data_mem[retire_tag_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid <= '0;
        end else begin
            if (alloc_en_i) begin
                valid[alloc_tag_i] <= 1'b0;
            end
            for (int i = 0; i < WB_PORTS; i++) begin
                if (wb_we[i]) begin
                    valid[wb_tag[i]] <= 1'b1;
                end
            end
        end
    end

    // all five units store their results
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < WB_PORTS; i++) begin
            if (wb_we[i]) begin
                data_mem[wb_tag[i]] <= wb_data[i];
            end
        end
    end

    always_comb begin
        wb_collide    = 1'b0;
        wb_hits_alloc = 1'b0;
        for (int i = 0; i < WB_PORTS; i++) begin
            if (wb_we[i] && alloc_en_i && (wb_tag[i] == alloc_tag_i)) begin
                wb_hits_alloc = 1'b1;
            end
            for (int j = i + 1; j < WB_PORTS; j++) begin
                if (wb_we[i] && wb_we[j] && (wb_tag[i] == wb_tag[j])) begin
                    wb_collide = 1'b1;
                end
            end
        end
    end

    // each tag has exactly one producer in flight
    a_wb_unique_tag: assert property (
        @(posedge clk_i) disable iff (reset_i) !wb_collide
    ) else $error("rename_rrf: two writeback ports carry the same tag");

    // allocator never hands out an entry that is still being written
    a_wb_not_alloc: assert property (
        @(posedge clk_i) disable iff (reset_i) !wb_hits_alloc
    ) else $error("rename_rrf: writeback to an entry being allocated");

endmodule

//--- design/rename_top.sv
`include "rename_defs.svh"

module rename_top import rename_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // dispatch
    input  logic      dispatch_en_i,
    input  arf_idx_t  dispatch_dst_i,
    input  arf_idx_t  rs1_idx_i,
    input  arf_idx_t  rs2_idx_i,
    output reg_data_t rs1_data_o,
    output logic      rs1_ready_o,
    output reg_data_t rs2_data_o,
    output logic      rs2_ready_o,
    output rrf_tag_t  alloc_tag_o,
    output logic      full_o,

    // writeback
    input  logic      wb_alu1_we_i,
    input  rrf_tag_t  wb_alu1_tag_i,
    input  reg_data_t wb_alu1_data_i,
    input  logic      wb_alu2_we_i,
    input  rrf_tag_t  wb_alu2_tag_i,
    input  reg_data_t wb_alu2_data_i,
    input  logic      wb_ldst_we_i,
    input  rrf_tag_t  wb_ldst_tag_i,
    input  reg_data_t wb_ldst_data_i,
    input  logic      wb_mul_we_i,
    input  rrf_tag_t  wb_mul_tag_i,
    input  reg_data_t wb_mul_data_i,
    input  logic      wb_branch_we_i,
    input  rrf_tag_t  wb_branch_tag_i,
    input  reg_data_t wb_branch_data_i,

    // commit
    input  logic      commit_en_i,
    output logic      commit_ready_o
);

    wb_bus_if   wb ();
    rrf_read_if rd ();

    rrf_tag_t  retire_tag;
    arf_idx_t  retire_dst;
    logic      retire_valid;
    reg_data_t retire_data;

    // top level acts as the writeback source
    assign wb.alu1_we     = wb_alu1_we_i;
    assign wb.alu1_tag    = wb_alu1_tag_i;
    assign wb.alu1_data   = wb_alu1_data_i;
    assign wb.alu2_we     = wb_alu2_we_i;
    assign wb.alu2_tag    = wb_alu2_tag_i;
    assign wb.alu2_data   = wb_alu2_data_i;
    assign wb.ldst_we     = wb_ldst_we_i;
    assign wb.ldst_tag    = wb_ldst_tag_i;
    assign wb.ldst_data   = wb_ldst_data_i;
    assign wb.mul_we      = wb_mul_we_i;
    assign wb.mul_tag     = wb_mul_tag_i;
    assign wb.mul_data    = wb_mul_data_i;
    assign wb.branch_we   = wb_branch_we_i;
    assign wb.branch_tag  = wb_branch_tag_i;
    assign wb.branch_data = wb_branch_data_i;

    rrf_alloc u_alloc (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dispatch_en_i  (dispatch_en_i),
        .dispatch_dst_i (dispatch_dst_i),
        .commit_en_i    (commit_en_i),
        .entry_valid_i  (retire_valid),
        .alloc_tag_o    (alloc_tag_o),
        .retire_tag_o   (retire_tag),
        .retire_dst_o   (retire_dst),
        .full_o         (full_o),
        .commit_ready_o (commit_ready_o)
    );

    rename_rrf u_rrf (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .wb             (wb.sink),
        .rd             (rd.responder),
        .alloc_en_i     (dispatch_en_i),
        .alloc_tag_i    (alloc_tag_o),
        .retire_tag_i   (retire_tag),
        .retire_valid_o (retire_valid),
        .retire_data_o  (retire_data)
    );

    arf_table u_arf (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rs1_idx_i     (rs1_idx_i),
        .rs2_idx_i     (rs2_idx_i),
        .rd            (rd.requester),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .rs1_ready_o   (rs1_ready_o),
        .rs2_ready_o   (rs2_ready_o),
        .rename_en_i   (dispatch_en_i),
        .rename_dst_i  (dispatch_dst_i),
        .rename_tag_i  (alloc_tag_o),
        .commit_en_i   (commit_en_i),
        .commit_dst_i  (retire_dst),
        .commit_tag_i  (retire_tag),
        .commit_data_i (retire_data)
    );

endmodule

//--- design/rrf_alloc.sv
`include "rename_defs.svh"

module rrf_alloc import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     dispatch_en_i,
    input  arf_idx_t dispatch_dst_i,
    input  logic     commit_en_i,
    input  logic     entry_valid_i,
    output rrf_tag_t alloc_tag_o,
    output rrf_tag_t retire_tag_o,
    output arf_idx_t retire_dst_o,
    output logic     full_o,
    output logic     commit_ready_o
);

    rrf_tag_t   head;
    rrf_tag_t   tail;
    rrf_count_t count;
    logic       empty;

    // destination register of every entry in flight
    arf_idx_t dst_mem [`RRF_NUM];

    assign full_o  = (count == rrf_count_t'(`RRF_NUM));
    assign empty   = (count == '0);

    assign alloc_tag_o    = head;
    assign retire_tag_o   = tail;
    assign retire_dst_o   = dst_mem[tail];
    assign commit_ready_o = !empty && entry_valid_i;

    // pointers wrap on their own since RRF_NUM is a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_en_i) begin
                head <= head + 1'b1;
            end
            if (commit_en_i) begin
                tail <= tail + 1'b1;
            end
            case ({dispatch_en_i, commit_en_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (dispatch_en_i) begin
            dst_mem[head] <= dispatch_dst_i;
        end
    end

    // producer must honour full_o
    a_no_dispatch_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i) dispatch_en_i |-> !full_o
    ) else $error("rrf_alloc: dispatch while full");

    // commit only once the oldest result has been written back
    a_no_commit_when_not_ready: assert property (
        @(posedge clk_i) disable iff (reset_i) commit_en_i |-> commit_ready_o
    ) else $error("rrf_alloc: commit while not ready");

endmodule

//--- include/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// rename register file
`define RRF_NUM 16
`define RRF_SEL 4

// architectural register file
`define ARF_NUM 32
`define ARF_SEL 5

// datapath width
`define DATA_LEN 32

`endif

//--- verilog.f
+incdir+include
design/rename_pkg.sv
design/rename_ifs.sv
design/rrf_alloc.sv
design/rename_rrf.sv
design/arf_table.sv
design/rename_top.sv
bench/rename_tb.sv
